/* Makefile */
# Verilator build and run for the chip I/O testbench

TOP = chip_io_tb

.PHONY: all lint clean

# Build, run, and pass only if the testbench printed its pass line
all:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^Test OK$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module chip_io_top

clean:
	rm -rf obj_dir

/* include/chip_io_vectors.svh */
// Register and pad table, run with the strap low so JTAG stays off
// Pad columns follow out ^ invert, and oe & ~(open_drain & pad out)

`ifndef CHIP_IO_VECTORS_SVH
`define CHIP_IO_VECTORS_SVH

typedef enum logic [1:0] {
  OP_WRITE,  // Register write, then pad check
  OP_DRIVE,  // New pad input pattern
  OP_READ    // Wait, then compare rdata
} vec_op_e;

typedef logic [8*12-1:0] vec_name_t;

typedef struct packed {
  vec_name_t              name;
  vec_op_e                op;
  chip_io_pkg::reg_addr_e addr;
  chip_io_pkg::pad_vec_t  data;
  chip_io_pkg::pad_vec_t  exp_out;
  chip_io_pkg::pad_vec_t  exp_oe;
  chip_io_pkg::pad_vec_t  exp_rdata;
} vec_entry_t;

localparam int NumVectors = 21;

localparam vec_entry_t Vectors [NumVectors] = '{
  // name, op, addr, data, pad out, pad oe, rdata
  '{"rst_out",    OP_READ,  chip_io_pkg::PAD_OUT,        12'h000, 12'h000, 12'h000, 12'h000},
  '{"rst_oe",     OP_READ,  chip_io_pkg::PAD_OE,         12'h000, 12'h000, 12'h000, 12'h000},
  '{"rst_inv",    OP_READ,  chip_io_pkg::PAD_INVERT,     12'h000, 12'h000, 12'h000, 12'h000},
  '{"rst_od",     OP_READ,  chip_io_pkg::PAD_OPEN_DRAIN, 12'h000, 12'h000, 12'h000, 12'h000},
  '{"rst_in",     OP_READ,  chip_io_pkg::PAD_IN,         12'h000, 12'h000, 12'h000, 12'h000},
  '{"rst_status", OP_READ,  chip_io_pkg::STATUS,         12'h000, 12'h000, 12'h000, 12'h000},
  '{"wr_out",     OP_WRITE, chip_io_pkg::PAD_OUT,        12'hA5C, 12'hA5C, 12'h000, 12'h000},
  '{"wr_oe",      OP_WRITE, chip_io_pkg::PAD_OE,         12'hF0F, 12'hA5C, 12'hF0F, 12'h000},
  '{"wr_inv",     OP_WRITE, chip_io_pkg::PAD_INVERT,     12'h3C3, 12'h99F, 12'hF0F, 12'h000},
  '{"wr_od",      OP_WRITE, chip_io_pkg::PAD_OPEN_DRAIN, 12'h0FF, 12'h99F, 12'hF00, 12'h000},
  '{"rd_od",      OP_READ,  chip_io_pkg::PAD_OPEN_DRAIN, 12'h000, 12'h99F, 12'hF00, 12'h0FF},
  '{"wr_in_ro",   OP_WRITE, chip_io_pkg::PAD_IN,         12'hFFF, 12'h99F, 12'hF00, 12'h000},
  '{"rd_out",     OP_READ,  chip_io_pkg::PAD_OUT,        12'h000, 12'h99F, 12'hF00, 12'hA5C},
  '{"drv_in",     OP_DRIVE, chip_io_pkg::PAD_IN,         12'h5A3, 12'h99F, 12'hF00, 12'h000},
  '{"rd_in",      OP_READ,  chip_io_pkg::PAD_IN,         12'h000, 12'h99F, 12'hF00, 12'h660},
  '{"rd_status",  OP_READ,  chip_io_pkg::STATUS,         12'h000, 12'h99F, 12'hF00, 12'h000},
  // DIO pads 8..11 as plain GPIOs
  '{"dio_out",    OP_WRITE, chip_io_pkg::PAD_OUT,        12'hF00, 12'hCC3, 12'hF0C, 12'h000},
  '{"dio_drv",    OP_DRIVE, chip_io_pkg::PAD_IN,         12'hE00, 12'hCC3, 12'hF0C, 12'h000},
  '{"dio_in",     OP_READ,  chip_io_pkg::PAD_IN,         12'h000, 12'hCC3, 12'hF0C, 12'hDC3},
  '{"clr_inv",    OP_WRITE, chip_io_pkg::PAD_INVERT,     12'h000, 12'hF00, 12'hF0F, 12'h000},
  '{"clr_od",     OP_WRITE, chip_io_pkg::PAD_OPEN_DRAIN, 12'h000, 12'hF00, 12'hF0F, 12'h000}
};

`endif

/* dv/chip_io_tb.sv */
// Table, random GPIO rounds, then JTAG IDCODE and BYPASS through the pads
// Strap level is held through each reset; stops at the first mismatch

`timescale 1ns/1ps

module chip_io_tb;

  localparam int ResetCycles = 16;
  localparam int ReadWait    = 4;
  localparam int TckHalf     = 6;   // clk cycles per TCK half period
  localparam int NumRounds   = 16;
  localparam int JtagCycles  = 70;  // Bound on TCK cycles over all JTAG tests
  localparam chip_io_pkg::pad_vec_t JtagPadMask = 12'hF80;  // Pads 7..11

  logic                   clk = 1'b0;
  logic                   rst_n;
  chip_io_pkg::pad_vec_t  pad_in;
  chip_io_pkg::pad_vec_t  pad_out;
  chip_io_pkg::pad_vec_t  pad_oe;
  logic                   reg_we;
  chip_io_pkg::reg_addr_e reg_addr;
  chip_io_pkg::pad_vec_t  reg_wdata;
  chip_io_pkg::pad_vec_t  reg_rdata;
  int unsigned            cycle_cnt = 0;

  `include "chip_io_vectors.svh"

  localparam int TimeoutCycles = 2 * (2 * ResetCycles + NumVectors * (ReadWait + 2) +
                                      NumRounds * (ReadWait + 6) + JtagCycles * 2 * TckHalf);

  chip_io_top DUT (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .pad_in_i    ( pad_in    ),
    .pad_out_o   ( pad_out   ),
    .pad_oe_o    ( pad_oe    ),
    .reg_we_i    ( reg_we    ),
    .reg_addr_i  ( reg_addr  ),
    .reg_wdata_i ( reg_wdata ),
    .reg_rdata_o ( reg_rdata )
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("Run did not finish within %0d cycles", TimeoutCycles);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_rdata(input vec_name_t name, input chip_io_pkg::pad_vec_t exp_val,
                             input chip_io_pkg::pad_vec_t act_val);
    if (act_val !== exp_val) begin
      $display("** Error %0s: rdata expected %03h, actual %03h", name, exp_val, act_val);
      abort_run();
    end
  endtask

  task automatic check_pads(input vec_name_t name, input chip_io_pkg::pad_ctrl_t exp_val,
                            input chip_io_pkg::pad_ctrl_t act_val);
    if (act_val !== exp_val) begin
      $display("** Error %0s: out/oe expected %03h/%03h, actual %03h/%03h", name,
               exp_val.out, exp_val.oe, act_val.out, act_val.oe);
      abort_run();
    end
  endtask

  // Used for IDCODE and BYPASS shift results
  task automatic check_idcode(input vec_name_t name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("** Error %0s: DR expected %08h, actual %08h", name, exp_val, act_val);
      abort_run();
    end
  endtask

  // Pad level is out ^ invert
  function automatic chip_io_pkg::pad_ctrl_t expect_pads(input chip_io_pkg::pad_vec_t out,
      input chip_io_pkg::pad_vec_t oe, input chip_io_pkg::pad_vec_t inv,
      input chip_io_pkg::pad_vec_t od);
    chip_io_pkg::pad_ctrl_t exp_val;
    exp_val.out = out ^ inv;
    exp_val.oe  = oe;
    for (int i = 0; i < chip_io_pkg::NumPads; i++) begin
      if (od[i] && exp_val.out[i]) begin
        exp_val.oe[i] = 1'b0;  // Open drain never drives a 1
      end
    end
    return exp_val;
  endfunction

  function automatic chip_io_pkg::pad_vec_t random_pads();
    logic [31:0] bits;
    bits = $urandom;
    return bits[chip_io_pkg::NumPads-1:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Drivers start and end on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic reset_dut(input chip_io_pkg::pad_vec_t pins);
    pad_in = pins;
    rst_n  = 1'b0;
    repeat (ResetCycles) @(negedge clk);
    rst_n  = 1'b1;
  endtask

  task automatic write_reg(input chip_io_pkg::reg_addr_e addr, input chip_io_pkg::pad_vec_t data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we    = 1'b0;
  endtask

  task automatic drive_pads(input chip_io_pkg::pad_vec_t pins);
    pad_in = pins;
    @(negedge clk);
  endtask

  task automatic read_reg(input chip_io_pkg::reg_addr_e addr, output chip_io_pkg::pad_vec_t data);
    reg_addr = addr;
    repeat (ReadWait) @(negedge clk);  // Covers the input synchronizers
    data = reg_rdata;
  endtask

  task automatic jtag_cycle(input logic tms, input logic tdi, output logic tdo);
    pad_in[chip_io_pkg::TckIdx] = 1'b0;
    pad_in[chip_io_pkg::TmsIdx] = tms;
    pad_in[chip_io_pkg::TdiIdx] = tdi;
    repeat (TckHalf) @(negedge clk);
    tdo = pad_out[chip_io_pkg::TdoIdx];  // Host samples just before the rise
    pad_in[chip_io_pkg::TckIdx] = 1'b1;
    repeat (TckHalf) @(negedge clk);
  endtask

  task automatic tap_reset();
    logic tdo;
    repeat (5) jtag_cycle(1'b1, 1'b0, tdo);
    jtag_cycle(1'b0, 1'b0, tdo);  // Run-Test/Idle
  endtask

  task automatic shift_ir(input logic [1:0] instr);
    logic tdo;
    jtag_cycle(1'b1, 1'b0, tdo);      // Select-DR
    jtag_cycle(1'b1, 1'b0, tdo);      // Select-IR
    jtag_cycle(1'b0, 1'b0, tdo);      // Capture-IR
    jtag_cycle(1'b0, 1'b0, tdo);      // Shift-IR
    jtag_cycle(1'b0, instr[0], tdo);
    jtag_cycle(1'b1, instr[1], tdo);  // Last bit moves on to Exit1-IR
    jtag_cycle(1'b1, 1'b0, tdo);      // Update-IR
    jtag_cycle(1'b0, 1'b0, tdo);      // IR loads on this rise
  endtask

  task automatic shift_dr(input int nbits, input logic [31:0] tdi_bits,
                          output logic [31:0] tdo_bits);
    logic        tdo;
    logic [31:0] tdi_sr;
    tdi_sr   = tdi_bits;
    tdo_bits = '0;
    jtag_cycle(1'b1, 1'b0, tdo);  // Select-DR
    jtag_cycle(1'b0, 1'b0, tdo);  // Capture-DR
    jtag_cycle(1'b0, 1'b0, tdo);  // Enters Shift-DR as DR loads on this rise
    for (int i = 0; i < nbits; i++) begin
      jtag_cycle(i == nbits - 1, tdi_sr[0], tdo);
      tdi_sr   = tdi_sr >> 1;
      tdo_bits = {tdo, tdo_bits[31:1]};
    end
    tdo_bits = tdo_bits >> (32 - nbits);  // LSB first
    jtag_cycle(1'b1, 1'b0, tdo);  // Update-DR
    jtag_cycle(1'b0, 1'b0, tdo);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    vec_entry_t            v;
    chip_io_pkg::pad_vec_t rdata;
    chip_io_pkg::pad_vec_t out;
    chip_io_pkg::pad_vec_t oe;
    chip_io_pkg::pad_vec_t inv;
    chip_io_pkg::pad_vec_t od;
    chip_io_pkg::pad_vec_t pins;
    logic [31:0]           tdo_bits;
    logic [31:0]           rbits;

    void'($urandom(32'h6f38));
    reg_we    = 1'b0;
    reg_addr  = chip_io_pkg::PAD_OUT;
    reg_wdata = '0;
    reset_dut('0);  // Strap low

    for (int i = 0; i < NumVectors; i++) begin
      v = Vectors[i];
      case (v.op)
        OP_WRITE: write_reg(v.addr, v.data);
        OP_DRIVE: drive_pads(v.data);
        default: begin
          read_reg(v.addr, rdata);
          check_rdata(v.name, v.exp_rdata, rdata);
        end
      endcase
      check_pads(v.name, {v.exp_out, v.exp_oe}, {pad_out, pad_oe});
    end

    // Random GPIO rounds over all 12 pads
    for (int r = 0; r < NumRounds; r++) begin
      out  = random_pads();
      oe   = random_pads();
      inv  = random_pads();
      od   = random_pads();
      pins = random_pads();
      write_reg(chip_io_pkg::PAD_OUT, out);
      write_reg(chip_io_pkg::PAD_OE, oe);
      write_reg(chip_io_pkg::PAD_INVERT, inv);
      write_reg(chip_io_pkg::PAD_OPEN_DRAIN, od);
      check_pads("rand_pads", expect_pads(out, oe, inv, od), {pad_out, pad_oe});
      drive_pads(pins);
      read_reg(chip_io_pkg::PAD_IN, rdata);
      check_rdata("rand_in", pins ^ inv, rdata);
    end

    // Second reset with the strap high and TRST released
    // TCK, TDI and TDO pads high so the tie-off is visible
    pins = '0;
    pins[chip_io_pkg::JtagEnIdx] = 1'b1;
    pins[chip_io_pkg::TrstIdx]   = 1'b1;
    pins[chip_io_pkg::TckIdx]    = 1'b1;
    pins[chip_io_pkg::TdiIdx]    = 1'b1;
    pins[chip_io_pkg::TdoIdx]    = 1'b1;
    reset_dut(pins);
    read_reg(chip_io_pkg::STATUS, rdata);
    check_rdata("jtag_status", 12'h001, rdata);
    read_reg(chip_io_pkg::PAD_IN, rdata);
    check_rdata("jtag_pad_in", (pins & ~JtagPadMask) | (12'h001 << chip_io_pkg::TmsIdx), rdata);

    // Core tries to drive the JTAG pads
    write_reg(chip_io_pkg::PAD_OUT, JtagPadMask);
    write_reg(chip_io_pkg::PAD_OE, JtagPadMask);
    check_pads("jtag_pads", {12'h000, 12'h001 << chip_io_pkg::TdoIdx}, {pad_out, pad_oe});

    tap_reset();
    shift_dr(32, '0, tdo_bits);
    check_idcode("idcode", 32'h0A5C11E3, tdo_bits);

    // Bypass delays TDI by one bit with the captured 0 first
    shift_ir(2'b11);
    rbits = $urandom;
    shift_dr(8, {24'h0, rbits[7:0]}, tdo_bits);
    check_idcode("bypass", {24'h0, rbits[6:0], 1'b0}, tdo_bits);

    $display("Test OK");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
rtl/chip_io_pkg.sv
rtl/pad_ring.sv
rtl/jtag_overlay_mux.sv
rtl/jtag_tap.sv
rtl/pad_ctrl_regs.sv
rtl/chip_io_top.sv
dv/chip_io_tb.sv

/* rtl/chip_io_pkg.sv */
// Shared pad map, tie-offs and types for the 12-pad I/O ring
// Pads 0..7 are MIO and 8..11 are DIO, with the JTAG pads on the DIOs

package chip_io_pkg;

  localparam int NumPads    = 12;
  localparam int NumMioPads = 8;

  // JTAG pad map
  localparam int JtagEnIdx = 6;              // Strap, MIO 6
  localparam int TrstIdx   = 7;              // MIO 7
  localparam int TckIdx    = NumMioPads + 0;
  localparam int TmsIdx    = NumMioPads + 1; // Doubles as chip select
  localparam int TdiIdx    = NumMioPads + 2;
  localparam int TdoIdx    = NumMioPads + 3;

  typedef logic [NumPads-1:0] pad_vec_t;

  // Core view of the JTAG pads while JTAG owns them, chip select is active low
  localparam pad_vec_t JtagTieOff = pad_vec_t'(1) << TmsIdx;

  localparam logic [31:0] JtagIdcode = 32'h0A5C11E3;

  typedef struct packed {
    pad_vec_t out;
    pad_vec_t oe;
  } pad_ctrl_t;

  typedef struct packed {
    pad_vec_t invert;
    pad_vec_t open_drain;
  } pad_attr_t;

  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic trst_n;
  } jtag_req_t;

  typedef enum logic [2:0] {
    PAD_OUT        = 3'd0,
    PAD_OE         = 3'd1,
    PAD_INVERT     = 3'd2,
    PAD_OPEN_DRAIN = 3'd3,
    PAD_IN         = 3'd4, // Read only
    STATUS         = 3'd5  // Read only
  } reg_addr_e;

  typedef enum logic [3:0] {
    TEST_LOGIC_RESET, RUN_TEST_IDLE,
    SELECT_DR, CAPTURE_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPDATE_DR,
    SELECT_IR, CAPTURE_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
  } tap_state_e;

  typedef enum logic [1:0] {
    IDCODE = 2'b01,
    BYPASS = 2'b11
  } tap_instr_e;

endpackage

/* rtl/chip_io_top.sv */
// I/O subsystem top: GPIO regs, JTAG overlay, TAP and pad ring
// Single clock; pads come as separate in, out and oe vectors

`timescale 1ns/1ps

module chip_io_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Pads
  input  chip_io_pkg::pad_vec_t  pad_in_i,
  output chip_io_pkg::pad_vec_t  pad_out_o,
  output chip_io_pkg::pad_vec_t  pad_oe_o,
  // Register port
  input  logic                   reg_we_i,
  input  chip_io_pkg::reg_addr_e reg_addr_i,
  input  chip_io_pkg::pad_vec_t  reg_wdata_i,
  output chip_io_pkg::pad_vec_t  reg_rdata_o
);

  chip_io_pkg::pad_ctrl_t core_ctrl;
  chip_io_pkg::pad_attr_t core_attr;
  chip_io_pkg::pad_ctrl_t ring_ctrl;
  chip_io_pkg::pad_vec_t  ring_in;
  chip_io_pkg::pad_vec_t  core_in;
  chip_io_pkg::jtag_req_t jtag_req;
  logic                   jtag_tdo;
  logic                   jtag_en;

  pad_ring u_pad_ring (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .pad_in_i  ( pad_in_i  ),
    .pad_out_o ( pad_out_o ),
    .pad_oe_o  ( pad_oe_o  ),
    .ctrl_i    ( ring_ctrl ),
    .attr_i    ( core_attr ), // Also on JTAG pads
    .in_o      ( ring_in   )
  );

  jtag_overlay_mux u_jtag_mux (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .core_ctrl_i ( core_ctrl ),
    .core_in_o   ( core_in   ),
    .ring_ctrl_o ( ring_ctrl ),
    .ring_in_i   ( ring_in   ),
    .jtag_o      ( jtag_req  ),
    .tdo_i       ( jtag_tdo  ),
    .jtag_en_o   ( jtag_en   )
  );

  jtag_tap u_jtag_tap (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .jtag_i  ( jtag_req ),
    .tdo_o   ( jtag_tdo )
  );

  pad_ctrl_regs u_pad_ctrl_regs (
    .clk_i     ( clk_i       ),
    .rst_n_i   ( rst_n_i     ),
    .we_i      ( reg_we_i    ),
    .addr_i    ( reg_addr_i  ),
    .wdata_i   ( reg_wdata_i ),
    .rdata_o   ( reg_rdata_o ),
    .pad_in_i  ( core_in     ),
    .jtag_en_i ( jtag_en     ),
    .ctrl_o    ( core_ctrl   ),
    .attr_o    ( core_attr   )
  );

endmodule

/* rtl/jtag_overlay_mux.sv */
// Strap is taken once, 3 edges after reset, and holds until the next reset
// Strap must be stable through reset release; TAP is held in reset while off

`timescale 1ns/1ps

module jtag_overlay_mux (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Core side
  input  chip_io_pkg::pad_ctrl_t core_ctrl_i,
  output chip_io_pkg::pad_vec_t  core_in_o,
  // Pad ring side
  output chip_io_pkg::pad_ctrl_t ring_ctrl_o,
  input  chip_io_pkg::pad_vec_t  ring_in_i,
  // TAP side
  output chip_io_pkg::jtag_req_t jtag_o,
  input  logic                   tdo_i,
  output logic                   jtag_en_o
);

  //////////////////////////////////////////////////////////////////////
  // Strap sampling
  //////////////////////////////////////////////////////////////////////

  logic [1:0] strap_cnt_q;
  logic       jtag_en_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      strap_cnt_q <= 2'd0;
      jtag_en_q   <= 1'b0;
    end else begin
      if (strap_cnt_q != 2'd3) begin
        strap_cnt_q <= strap_cnt_q + 2'd1;
      end
      if (strap_cnt_q == 2'd2) begin  // Third edge, sync chain now valid
        jtag_en_q <= ring_in_i[chip_io_pkg::JtagEnIdx];
      end
    end
  end

  assign jtag_en_o = jtag_en_q;

  //////////////////////////////////////////////////////////////////////
  // Pad steering
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ring_ctrl_o = core_ctrl_i;
    core_in_o   = ring_in_i;
    if (jtag_en_q) begin
      // JTAG inputs are never driven
      ring_ctrl_o.out[chip_io_pkg::TckIdx]  = 1'b0;
      ring_ctrl_o.oe[chip_io_pkg::TckIdx]   = 1'b0;
      ring_ctrl_o.out[chip_io_pkg::TmsIdx]  = 1'b0;
      ring_ctrl_o.oe[chip_io_pkg::TmsIdx]   = 1'b0;
      ring_ctrl_o.out[chip_io_pkg::TdiIdx]  = 1'b0;
      ring_ctrl_o.oe[chip_io_pkg::TdiIdx]   = 1'b0;
      ring_ctrl_o.out[chip_io_pkg::TrstIdx] = 1'b0;
      ring_ctrl_o.oe[chip_io_pkg::TrstIdx]  = 1'b0;
      ring_ctrl_o.out[chip_io_pkg::TdoIdx]  = tdo_i;
      ring_ctrl_o.oe[chip_io_pkg::TdoIdx]   = 1'b1;

      core_in_o[chip_io_pkg::TckIdx]  = chip_io_pkg::JtagTieOff[chip_io_pkg::TckIdx];
      core_in_o[chip_io_pkg::TmsIdx]  = chip_io_pkg::JtagTieOff[chip_io_pkg::TmsIdx];
      core_in_o[chip_io_pkg::TdiIdx]  = chip_io_pkg::JtagTieOff[chip_io_pkg::TdiIdx];
      core_in_o[chip_io_pkg::TdoIdx]  = chip_io_pkg::JtagTieOff[chip_io_pkg::TdoIdx];
      core_in_o[chip_io_pkg::TrstIdx] = chip_io_pkg::JtagTieOff[chip_io_pkg::TrstIdx];
    end
  end

  // Gated with jtag_en so a GPIO user never clocks the TAP
  assign jtag_o = '{
    tck:    jtag_en_q & ring_in_i[chip_io_pkg::TckIdx],
    tms:    jtag_en_q & ring_in_i[chip_io_pkg::TmsIdx],
    tdi:    jtag_en_q & ring_in_i[chip_io_pkg::TdiIdx],
    trst_n: jtag_en_q & ring_in_i[chip_io_pkg::TrstIdx]
  };

endmodule

/* rtl/jtag_tap.sv */
// TAP oversampled on clk_i; TCK must stay stable for several clk_i cycles
// Only IDCODE and BYPASS, no debug module behind it

`timescale 1ns/1ps

module jtag_tap (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  chip_io_pkg::jtag_req_t jtag_i,
  output logic                   tdo_o
);

  logic                    tck_q;
  logic                    tck_rise;
  logic                    tck_fall;
  chip_io_pkg::tap_state_e state_q;
  chip_io_pkg::tap_state_e state_d;
  logic [1:0]              ir_q;
  logic [1:0]              ir_shift_q;
  logic [31:0]             dr_q;
  logic                    bypass_q;
  logic                    sel_idcode;

  // TCK is already synchronized in the pad ring
  assign tck_rise = jtag_i.tck & ~tck_q;
  assign tck_fall = ~jtag_i.tck & tck_q;

  //////////////////////////////////////////////////////////////////////
  // TAP state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (state_q)
      chip_io_pkg::TEST_LOGIC_RESET:
        state_d = jtag_i.tms ? chip_io_pkg::TEST_LOGIC_RESET : chip_io_pkg::RUN_TEST_IDLE;
      chip_io_pkg::RUN_TEST_IDLE:
        state_d = jtag_i.tms ? chip_io_pkg::SELECT_DR : chip_io_pkg::RUN_TEST_IDLE;
      chip_io_pkg::SELECT_DR:
        state_d = jtag_i.tms ? chip_io_pkg::SELECT_IR : chip_io_pkg::CAPTURE_DR;
      chip_io_pkg::CAPTURE_DR, chip_io_pkg::SHIFT_DR:
        state_d = jtag_i.tms ? chip_io_pkg::EXIT1_DR : chip_io_pkg::SHIFT_DR;
      chip_io_pkg::EXIT1_DR:
        state_d = jtag_i.tms ? chip_io_pkg::UPDATE_DR : chip_io_pkg::PAUSE_DR;
      chip_io_pkg::PAUSE_DR:
        state_d = jtag_i.tms ? chip_io_pkg::EXIT2_DR : chip_io_pkg::PAUSE_DR;
      chip_io_pkg::EXIT2_DR:
        state_d = jtag_i.tms ? chip_io_pkg::UPDATE_DR : chip_io_pkg::SHIFT_DR;
      chip_io_pkg::SELECT_IR:
        state_d = jtag_i.tms ? chip_io_pkg::TEST_LOGIC_RESET : chip_io_pkg::CAPTURE_IR;
      chip_io_pkg::CAPTURE_IR, chip_io_pkg::SHIFT_IR:
        state_d = jtag_i.tms ? chip_io_pkg::EXIT1_IR : chip_io_pkg::SHIFT_IR;
      chip_io_pkg::EXIT1_IR:
        state_d = jtag_i.tms ? chip_io_pkg::UPDATE_IR : chip_io_pkg::PAUSE_IR;
      chip_io_pkg::PAUSE_IR:
        state_d = jtag_i.tms ? chip_io_pkg::EXIT2_IR : chip_io_pkg::PAUSE_IR;
      chip_io_pkg::EXIT2_IR:
        state_d = jtag_i.tms ? chip_io_pkg::UPDATE_IR : chip_io_pkg::SHIFT_IR;
      default:  // Both update states
        state_d = jtag_i.tms ? chip_io_pkg::SELECT_DR : chip_io_pkg::RUN_TEST_IDLE;
    endcase
  end

  always_comb begin
    case (chip_io_pkg::tap_instr_e'(ir_q))
      chip_io_pkg::IDCODE: sel_idcode = 1'b1;
      chip_io_pkg::BYPASS: sel_idcode = 1'b0;
      default:             sel_idcode = 1'b0; // Unused codes act as BYPASS
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tck_q   <= 1'b0;
      state_q <= chip_io_pkg::TEST_LOGIC_RESET;
      ir_q    <= chip_io_pkg::IDCODE;
      tdo_o   <= 1'b0;
    end else begin
      tck_q <= jtag_i.tck;
      if (!jtag_i.trst_n || state_q == chip_io_pkg::TEST_LOGIC_RESET) begin
        ir_q <= chip_io_pkg::IDCODE;
      end else if (tck_rise && state_q == chip_io_pkg::UPDATE_IR) begin
        ir_q <= ir_shift_q;
      end
      if (!jtag_i.trst_n) begin
        state_q <= chip_io_pkg::TEST_LOGIC_RESET;
      end else if (tck_rise) begin
        state_q <= state_d;
      end
      // TDO changes on the falling edge only, holds outside shift
      if (tck_fall && state_q == chip_io_pkg::SHIFT_IR) begin
        tdo_o <= ir_shift_q[0];
      end else if (tck_fall && state_q == chip_io_pkg::SHIFT_DR) begin
        tdo_o <= sel_idcode ? dr_q[0] : bypass_q;
      end
    end
  end

  // Shift registers, reloaded in the capture states
  always_ff @(posedge clk_i) begin
    if (tck_rise) begin
      unique case (state_q)
        chip_io_pkg::CAPTURE_IR: ir_shift_q <= 2'b01;
        chip_io_pkg::SHIFT_IR:   ir_shift_q <= {jtag_i.tdi, ir_shift_q[1]};
        chip_io_pkg::CAPTURE_DR: begin
          dr_q     <= chip_io_pkg::JtagIdcode;
          bypass_q <= 1'b0;
        end
        chip_io_pkg::SHIFT_DR: begin
          if (sel_idcode) begin
            dr_q <= {jtag_i.tdi, dr_q[31:1]};
          end else begin
            bypass_q <= jtag_i.tdi;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

/* rtl/pad_ctrl_regs.sv */
// Plain write strobe, combinational read; no bus handshake
// Writes to PAD_IN and STATUS are dropped

`timescale 1ns/1ps

module pad_ctrl_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Register port
  input  logic                   we_i,
  input  chip_io_pkg::reg_addr_e addr_i,
  input  chip_io_pkg::pad_vec_t  wdata_i,
  output chip_io_pkg::pad_vec_t  rdata_o,
  // Readback sources
  input  chip_io_pkg::pad_vec_t  pad_in_i,
  input  logic                   jtag_en_i,
  // To the pads
  output chip_io_pkg::pad_ctrl_t ctrl_o,
  output chip_io_pkg::pad_attr_t attr_o
);

  chip_io_pkg::pad_vec_t out_q;
  chip_io_pkg::pad_vec_t oe_q;
  chip_io_pkg::pad_vec_t invert_q;
  chip_io_pkg::pad_vec_t open_drain_q;

  //////////////////////////////////////////////////////////////////////
  // Writable registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q        <= '0;
      oe_q         <= '0;
      invert_q     <= '0;
      open_drain_q <= '0;
    end else if (we_i) begin
      case (addr_i)
        chip_io_pkg::PAD_OUT:        out_q        <= wdata_i;
        chip_io_pkg::PAD_OE:         oe_q         <= wdata_i;
        chip_io_pkg::PAD_INVERT:     invert_q     <= wdata_i;
        chip_io_pkg::PAD_OPEN_DRAIN: open_drain_q <= wdata_i;
        default: ;  // Read only
      endcase
    end
  end

  assign ctrl_o = '{out: out_q, oe: oe_q};
  assign attr_o = '{invert: invert_q, open_drain: open_drain_q};

  //////////////////////////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (addr_i)
      chip_io_pkg::PAD_OUT:        rdata_o = out_q;
      chip_io_pkg::PAD_OE:         rdata_o = oe_q;
      chip_io_pkg::PAD_INVERT:     rdata_o = invert_q;
      chip_io_pkg::PAD_OPEN_DRAIN: rdata_o = open_drain_q;
      chip_io_pkg::PAD_IN:         rdata_o = pad_in_i;  // Already synced and inverted
      chip_io_pkg::STATUS:         rdata_o = chip_io_pkg::pad_vec_t'(jtag_en_i);
      default:                     rdata_o = '0;
    endcase
  end

endmodule

/* rtl/pad_ring.sv */
// Pads are split into in/out/oe, no real tristate or pulls
// Inputs cross into clk_i through two flops, so core sees them 2 edges late

`timescale 1ns/1ps

module pad_ring (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Pad side
  input  chip_io_pkg::pad_vec_t  pad_in_i,
  output chip_io_pkg::pad_vec_t  pad_out_o,
  output chip_io_pkg::pad_vec_t  pad_oe_o,
  // Core side
  input  chip_io_pkg::pad_ctrl_t ctrl_i,
  input  chip_io_pkg::pad_attr_t attr_i,
  output chip_io_pkg::pad_vec_t  in_o
);

  //////////////////////////////////////////////////////////////////////
  // Output attributes
  //////////////////////////////////////////////////////////////////////

  chip_io_pkg::pad_vec_t out_inv;

  for (genvar i = 0; i < chip_io_pkg::NumPads; i++) begin : g_pad_out
    assign out_inv[i] = ctrl_i.out[i] ^ attr_i.invert[i];

    // Open drain only ever drives low
    assign pad_oe_o[i] = ctrl_i.oe[i] & ~(attr_i.open_drain[i] & out_inv[i]);
  end

  assign pad_out_o = out_inv;

  //////////////////////////////////////////////////////////////////////
  // Input synchronizers
  //////////////////////////////////////////////////////////////////////

  chip_io_pkg::pad_vec_t in_meta_q;
  chip_io_pkg::pad_vec_t in_sync_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= pad_in_i;
      in_sync_q <= in_meta_q;
    end
  end

  // Invert after sync so the attribute can change without a glitch on the flops
  assign in_o = in_sync_q ^ attr_i.invert;

endmodule
